//--- Bender.yml
package:
  name: color_mapper

sources:
  - common/gamePkg.sv
  - render/pixelDecode.sv
  - render/pixelResult.sv
  - gameplay/livesTracker.sv
  - gameplay/scoreCounter.sv
  - logic/colorMapper.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/colorMapper_properties.sv
      - tb/colorMapperTb.sv

//--- common/gamePkg.sv
// screen coordinates are 10-bit unsigned with y growing downward; colours are 24-bit RGB
package gamePkg;

    // ------------------------------
    // sizes of the game objects
    // ------------------------------
    localparam int NumPipes    = 3;
    localparam int NumHearts   = 3;
    localparam int ScoreDigits = 9;

    // ball is a square, collision point sits at its far corner
    localparam int BallSize      = 30;
    localparam int BallRefOffset = 30;

    localparam int PipeWidth  = 50;
    localparam int PipeHeight = 100;

    // heart row along the top of the screen
    localparam int HeartX0    = 450;
    localparam int HeartPitch = 50;
    localparam int HeartY     = 20;
    localparam int HeartSize  = 50;

    // score only runs while the ball is lower than this line
    localparam int ScoreFloorY = 430;

    localparam int MaxLives = 3;

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [9:0] coord_t;

    // top-left corner of an object, or the beam position
    typedef struct packed {
        coord_t x;
        coord_t y;
    } objPos_t;

    typedef objPos_t [NumPipes-1:0] pipeSet_t;

    typedef logic [1:0] lives_t;

    // digit 0 is the least significant
    typedef logic [ScoreDigits-1:0][3:0] scoreBcd_t;

    typedef enum logic [1:0] {
        LayerBackground,
        LayerBall,
        LayerPipe,
        LayerHeart
    } layer_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // ------------------------------
    // palette
    // ------------------------------
    localparam rgb_t BallColor       = 24'hCC7711;
    localparam rgb_t PipeColor       = 24'h00FF44;
    localparam rgb_t HeartColor      = 24'hDD00FF;
    localparam rgb_t BackgroundColor = 24'h0000FF;
    localparam rgb_t BlankColor      = 24'h000000;

endpackage

//--- gameplay/livesTracker.sv
// a life is lost once per pipe entry; the ball must leave every pipe before the next hit counts
`timescale 1ns/10ps

module livesTracker
(
    input  logic              Clk,
    input  logic              Reset,
    input  gamePkg::objPos_t  Ball,
    input  gamePkg::pipeSet_t Pipes,
    output gamePkg::lives_t   Lives
);

    import gamePkg::*;

    typedef enum logic [2:0] {
        Alive3,
        Hit1,
        Alive2,
        Hit2,
        Alive1,
        Dead
    } lifeState_t;

    lifeState_t state;
    lifeState_t nextState;
    logic       collision;
    int         refX;
    int         refY;

    // ------------------------------
    // collision test
    // ------------------------------
    // reference point strictly inside a pipe
    always_comb
    begin
        refX = int'(Ball.x) + BallRefOffset;
        refY = int'(Ball.y) + BallRefOffset;
        collision = 1'b0;
        for (int p = 0; p < NumPipes; p++)
        begin
            if (refX > int'(Pipes[p].x) && refX < int'(Pipes[p].x) + PipeWidth &&
                refY > int'(Pipes[p].y) && refY < int'(Pipes[p].y) + PipeHeight)
            begin
                collision = 1'b1;
            end
        end
    end

    // ------------------------------
    // state machine
    // ------------------------------
    always_comb
    begin
        nextState = state;
        case (state)
            Alive3: if (collision) nextState = Hit1;
            Hit1:   if (!collision) nextState = Alive2;
            Alive2: if (collision) nextState = Hit2;
            Hit2:   if (!collision) nextState = Alive1;
            Alive1: if (collision) nextState = Dead;
            // dead until reset
            default: nextState = Dead;
        endcase
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            state <= Alive3;
        end
        else
        begin
            state <= nextState;
        end
    end

    // life already counts as lost during the hit
    always_comb
    begin
        case (state)
            Alive3:        Lives = lives_t'(MaxLives);
            Hit1, Alive2:  Lives = lives_t'(2);
            Hit2, Alive1:  Lives = lives_t'(1);
            default:       Lives = '0;
        endcase
    end

endmodule

//--- gameplay/scoreCounter.sv
// ScoreTickCycles must be 2 or more; score wraps to zero after 999999999
`timescale 1ns/10ps

module scoreCounter
#(
    parameter int ScoreTickCycles = 1048576
)
(
    input  logic               Clk,
    input  logic               Reset,
    input  gamePkg::objPos_t   Ball,
    input  gamePkg::lives_t    Lives,
    output gamePkg::scoreBcd_t Score
);

    import gamePkg::*;

    logic [$clog2(ScoreTickCycles)-1:0] tickCount;
    logic                               tickWrap;
    logic                               scoreEn;
    logic [ScoreDigits-1:0]             lowNines;
    scoreBcd_t                          scoreInc;

    // ------------------------------
    // tick divider
    // ------------------------------
    assign tickWrap = (tickCount == ScoreTickCycles - 1);

    // screen y grows downward, so a larger y is lower
    assign scoreEn = tickWrap && (int'(Ball.y) > ScoreFloorY) && (Lives != '0);

    // ------------------------------
    // decimal increment
    // ------------------------------
    // a digit moves when every digit below it is 9
    always_comb
    begin
        lowNines[0] = 1'b1;
        for (int i = 1; i < ScoreDigits; i++)
            lowNines[i] = lowNines[i-1] && (Score[i-1] == 4'd9);
        for (int i = 0; i < ScoreDigits; i++)
        begin
            if (!lowNines[i])
                scoreInc[i] = Score[i];
            else if (Score[i] == 4'd9)
                scoreInc[i] = 4'd0;
            else
                scoreInc[i] = Score[i] + 4'd1;
        end
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            tickCount <= '0;
            Score     <= '0;
        end
        else
        begin
            tickCount <= tickWrap ? '0 : tickCount + 1'b1;
            if (scoreEn)
                Score <= scoreInc;
        end
    end

endmodule

//--- logic/colorMapper.sv
// one draw position per clock, no flow control; Pixel lags its inputs by exactly one cycle
`timescale 1ns/10ps

module colorMapper
#(
    parameter int ScoreTickCycles = 1048576
)
(
    input  logic               Clk,
    input  logic               Reset,
    input  gamePkg::objPos_t   DrawPos,
    input  logic               Blank,
    input  gamePkg::objPos_t   Ball,
    input  gamePkg::pipeSet_t  Pipes,
    output gamePkg::rgb_t      Pixel,
    output gamePkg::lives_t    Lives,
    output gamePkg::scoreBcd_t Score
);

    import gamePkg::*;

    layer_t layer;

    // ------------------------------
    // decode
    // ------------------------------
    pixelDecode u_pixelDecode (
        .DrawPos (DrawPos),
        .Ball    (Ball),
        .Pipes   (Pipes),
        .Lives   (Lives),
        .Layer   (layer)
    );

    // ------------------------------
    // execute
    // ------------------------------
    livesTracker u_livesTracker (
        .Clk   (Clk),
        .Reset (Reset),
        .Ball  (Ball),
        .Pipes (Pipes),
        .Lives (Lives)
    );

    scoreCounter #(
        .ScoreTickCycles (ScoreTickCycles)
    ) u_scoreCounter (
        .Clk   (Clk),
        .Reset (Reset),
        .Ball  (Ball),
        .Lives (Lives),
        .Score (Score)
    );

    // ------------------------------
    // result
    // ------------------------------
    pixelResult u_pixelResult (
        .Clk   (Clk),
        .Reset (Reset),
        .Layer (layer),
        .Blank (Blank),
        .Pixel (Pixel)
    );

endmodule

//--- render/pixelDecode.sv
// purely combinational; boxes include left/top edges and exclude right/bottom, no wrap at screen edge
`timescale 1ns/10ps

module pixelDecode
(
    input  gamePkg::objPos_t  DrawPos,
    input  gamePkg::objPos_t  Ball,
    input  gamePkg::pipeSet_t Pipes,
    input  gamePkg::lives_t   Lives,
    output gamePkg::layer_t   Layer
);

    import gamePkg::*;

    logic ballOn;
    logic pipeOn;
    logic heartOn;

    // half-open box test, done in int so corner plus size cannot overflow
    function automatic logic inRect(objPos_t pos, int x0, int y0, int width, int height);
        int dx;
        int dy;
        dx = int'(pos.x) - x0;
        dy = int'(pos.y) - y0;
        return (dx >= 0) && (dx < width) && (dy >= 0) && (dy < height);
    endfunction

    // ------------------------------
    // object hit tests
    // ------------------------------
    always_comb
    begin
        ballOn = inRect(DrawPos, int'(Ball.x), int'(Ball.y), BallSize, BallSize);
    end

    always_comb
    begin
        pipeOn = 1'b0;
        for (int p = 0; p < NumPipes; p++)
        begin
            if (inRect(DrawPos, int'(Pipes[p].x), int'(Pipes[p].y), PipeWidth, PipeHeight))
            begin
                pipeOn = 1'b1;
            end
        end
    end

    // heart k survives while lives exceed 2 - k
    // so the leftmost one goes first
    always_comb
    begin
        heartOn = 1'b0;
        for (int k = 0; k < NumHearts; k++)
        begin
            if (int'(Lives) > NumHearts - 1 - k &&
                inRect(DrawPos, HeartX0 + k * HeartPitch, HeartY, HeartSize, HeartSize))
            begin
                heartOn = 1'b1;
            end
        end
    end

    // ------------------------------
    // layer priority
    // ------------------------------
    // ball is drawn over pipes, pipes over hearts
    always_comb
    begin
        if (ballOn)
        begin
            Layer = LayerBall;
        end
        else if (pipeOn)
        begin
            Layer = LayerPipe;
        end
        else if (heartOn)
        begin
            Layer = LayerHeart;
        end
        else
        begin
            Layer = LayerBackground;
        end
    end

endmodule

//--- render/pixelResult.sv
// one cycle of latency from layer to pixel; Blank is active low (high means visible area)
`timescale 1ns/10ps

module pixelResult
(
    input  logic            Clk,
    input  logic            Reset,
    input  gamePkg::layer_t Layer,
    input  logic            Blank,
    output gamePkg::rgb_t   Pixel
);

    import gamePkg::*;

    rgb_t nextPixel;

    // ------------------------------
    // palette lookup
    // ------------------------------
    always_comb
    begin
        if (!Blank)
        begin
            // outside the visible area
            nextPixel = BlankColor;
        end
        else
        begin
            case (Layer)
                LayerBall:
                begin
                    nextPixel = BallColor;
                end
                LayerPipe:
                begin
                    nextPixel = PipeColor;
                end
                LayerHeart:
                begin
                    nextPixel = HeartColor;
                end
                default:
                begin
                    nextPixel = BackgroundColor;
                end
            endcase
        end
    end

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            Pixel <= BlankColor;
        end
        else
        begin
            Pixel <= nextPixel;
        end
    end

endmodule

//--- tb/clockGen.sv
// free-running clock from time zero; Reset starts high and drops on a rising edge
`timescale 1ns/10ps

module clockGen
#(
    parameter int Period      = 100,
    parameter int ResetCycles = 4
)
(
    output logic Clk,
    output logic Reset
);

    initial
    begin
        Clk = 1'b0;
        forever #(Period / 2) Clk = ~Clk;
    end

    // reset held for a whole number of cycles
    initial
    begin
        Reset = 1'b1;
        repeat (ResetCycles) @(posedge Clk);
        Reset <= 1'b0;
    end

endmodule

//--- tb/colorMapperTb.sv
// runs colorMapper with a 16-cycle score tick; inputs change on rising edges, checks on falling
`timescale 1ns/10ps

module colorMapperTb;

    import gamePkg::*;

    localparam int TickCycles   = 16;
    localparam int ClkPeriod    = 100;
    localparam int LayerSamples = 200;

    // cycle budget of each test
    localparam int ResetBudget    = 10;
    localparam int LayerBudget    = 2 * LayerSamples + 10;
    localparam int ScoreBudget    = 17 * TickCycles;
    localparam int LivesBudget    = 100;
    localparam int ZeroBudget     = 4 * TickCycles;
    localparam int WatchdogCycles =
        2 * (ResetBudget + LayerBudget + ScoreBudget + LivesBudget + ZeroBudget);

    localparam rgb_t BallRgb       = 24'hCC7711;
    localparam rgb_t PipeRgb       = 24'h00FF44;
    localparam rgb_t HeartRgb      = 24'hDD00FF;
    localparam rgb_t BackgroundRgb = 24'h0000FF;

    // ball corners used by the tests
    localparam objPos_t BallOverPipe = '{x: 10'd120, y: 10'd180};
    localparam objPos_t BallOut      = '{x: 10'd10,  y: 10'd10};
    localparam objPos_t BallInPipe0  = '{x: 10'd90,  y: 10'd210};
    localparam objPos_t BallInPipe1  = '{x: 10'd240, y: 10'd170};
    localparam objPos_t BallLow      = '{x: 10'd600, y: 10'd450};
    localparam objPos_t BallHigh     = '{x: 10'd600, y: 10'd100};

    logic      Clk;
    logic      Reset;
    objPos_t   DrawPos;
    logic      Blank;
    objPos_t   Ball;
    pipeSet_t  Pipes;
    rgb_t      Pixel;
    lives_t    Lives;
    scoreBcd_t Score;

    integer seed        = 76538;
    int     errorCount  = 0;
    int     testErrors  = 0;
    int     testsRun    = 0;
    int     testsFailed = 0;
    int     expLives    = MaxLives;
    bit     hitActive   = 1'b0;

    clockGen #(
        .Period      (ClkPeriod),
        .ResetCycles (4)
    ) u_clockGen (
        .Clk   (Clk),
        .Reset (Reset)
    );

    colorMapper #(
        .ScoreTickCycles (TickCycles)
    ) u_colorMapper (
        .Clk     (Clk),
        .Reset   (Reset),
        .DrawPos (DrawPos),
        .Blank   (Blank),
        .Ball    (Ball),
        .Pipes   (Pipes),
        .Pixel   (Pixel),
        .Lives   (Lives),
        .Score   (Score)
    );

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic bit covers(int px, int py, int left, int top, int w, int h);
        return px >= left && px < left + w && py >= top && py < top + h;
    endfunction

    // ball over pipes over intact hearts over background
    function automatic rgb_t expectedColor(objPos_t pos, logic visible, int livesLeft);
        int px;
        int py;
        px = pos.x;
        py = pos.y;
        if (!visible)
            return 24'h000000;
        if (covers(px, py, Ball.x, Ball.y, BallSize, BallSize))
            return BallRgb;
        for (int p = 0; p < NumPipes; p++)
        begin
            if (covers(px, py, Pipes[p].x, Pipes[p].y, PipeWidth, PipeHeight))
                return PipeRgb;
        end
        for (int k = 0; k < NumHearts; k++)
        begin
            if (livesLeft > 2 - k &&
                covers(px, py, HeartX0 + k * HeartPitch, HeartY, HeartSize, HeartSize))
                return HeartRgb;
        end
        return BackgroundRgb;
    endfunction

    // reference point strictly inside a pipe
    function automatic bit refInPipe(objPos_t pos);
        int rx;
        int ry;
        rx = pos.x + BallRefOffset;
        ry = pos.y + BallRefOffset;
        for (int p = 0; p < NumPipes; p++)
        begin
            if (rx > Pipes[p].x && rx < Pipes[p].x + PipeWidth &&
                ry > Pipes[p].y && ry < Pipes[p].y + PipeHeight)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic scoreBcd_t toBcd(int value);
        scoreBcd_t digits;
        for (int i = 0; i < ScoreDigits; i++)
        begin
            digits[i] = 4'(value % 10);
            value = value / 10;
        end
        return digits;
    endfunction

    function automatic int randBelow(int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // ------------------------------
    // checks and stimulus
    // ------------------------------
    task automatic checkValue(string name, logic [35:0] actual, logic [35:0] expected);
        assert (actual === expected)
        else
        begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic reportFailure(string what);
        $display("Error at %0t: %s", $time, what);
        errorCount++;
        testErrors++;
    endtask

    task automatic endTest(string name);
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        $display("test %s: %s, %0d errors", name, (testErrors == 0) ? "ok" : "FAILED",
                 testErrors);
        testErrors = 0;
    endtask

    // colour is due one cycle after the position is applied
    task automatic samplePixel(objPos_t pos, logic visible);
        rgb_t expected;
        expected = expectedColor(pos, visible, expLives);
        @(posedge Clk);
        DrawPos <= pos;
        Blank   <= visible;
        @(negedge Clk);
        @(negedge Clk);
        checkValue("Pixel", Pixel, expected);
    endtask

    // near the ball, a pipe, the hearts or anywhere
    task automatic pickPos(output objPos_t pos);
        int sel;
        int p;
        int x;
        int y;
        sel = randBelow(4);
        p = randBelow(NumPipes);
        case (sel)
            0:
            begin
                x = Ball.x - 10 + randBelow(50);
                y = Ball.y - 10 + randBelow(50);
            end
            1:
            begin
                x = Pipes[p].x - 10 + randBelow(70);
                y = Pipes[p].y - 10 + randBelow(120);
            end
            2:
            begin
                x = HeartX0 - 10 + randBelow(170);
                y = HeartY - 10 + randBelow(70);
            end
            default:
            begin
                x = randBelow(640);
                y = randBelow(480);
            end
        endcase
        pos.x = coord_t'(x);
        pos.y = coord_t'(y);
    endtask

    // Lives holds at the first falling edge and settles at the second
    task automatic moveBall(objPos_t pos);
        @(posedge Clk);
        Ball <= pos;
        @(negedge Clk);
        checkValue("Lives", Lives, expLives);
        if (!hitActive && refInPipe(pos) && expLives > 0)
        begin
            expLives--;
            hitActive = 1'b1;
        end
        else if (hitActive && !refInPipe(pos))
        begin
            hitActive = 1'b0;
        end
        @(negedge Clk);
        checkValue("Lives", Lives, expLives);
    endtask

    task automatic checkHearts;
        objPos_t pos;
        for (int k = 0; k < NumHearts; k++)
        begin
            pos.x = coord_t'(HeartX0 + k * HeartPitch + HeartSize / 2);
            pos.y = coord_t'(HeartY + HeartSize / 2);
            samplePixel(pos, 1'b1);
        end
    endtask

    task automatic waitScoreChange(output bit advanced);
        scoreBcd_t start;
        start = Score;
        advanced = 1'b0;
        for (int c = 0; c < 2 * TickCycles && !advanced; c++)
        begin
            @(negedge Clk);
            advanced = (Score !== start);
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial
    begin
        objPos_t pos;
        bit      advanced;

        DrawPos  = '0;
        Blank    = 1'b0;
        Ball     = BallOverPipe;
        Pipes[0] = '{x: 10'd100, y: 10'd200};
        Pipes[1] = '{x: 10'd250, y: 10'd150};
        Pipes[2] = '{x: 10'd400, y: 10'd300};

        wait (Reset === 1'b1);
        wait (Reset === 1'b0);
        @(negedge Clk);
        checkValue("Lives", Lives, 3);
        checkValue("Score", Score, 0);
        checkValue("Pixel", Pixel, 0);
        endTest("reset");

        // ball corner overlapping the top of pipe 0
        samplePixel('{x: 10'd125, y: 10'd205}, 1'b1);
        for (int i = 0; i < LayerSamples; i++)
        begin
            pickPos(pos);
            samplePixel(pos, randBelow(8) != 0);
        end
        endTest("layer colours");

        @(posedge Clk);
        Ball <= BallLow;
        for (int n = 1; n <= 12; n++)
        begin
            waitScoreChange(advanced);
            if (!advanced)
                reportFailure("Score did not advance within two tick periods");
            checkValue("Score", Score, toBcd(n));
        end
        @(posedge Clk);
        Ball <= BallHigh;
        repeat (3 * TickCycles) @(negedge Clk);
        checkValue("Score", Score, toBcd(12));
        endTest("score");

        moveBall(BallOut);
        moveBall(BallInPipe0);
        checkHearts();
        repeat (5) @(negedge Clk);
        checkValue("Lives", Lives, expLives);
        moveBall(BallOut);
        moveBall(BallInPipe1);
        checkHearts();
        moveBall(BallOut);
        moveBall(BallInPipe0);
        checkHearts();
        moveBall(BallOut);
        moveBall(BallInPipe1);
        checkValue("Lives", Lives, 0);
        endTest("lives and hearts");

        moveBall(BallLow);
        repeat (3 * TickCycles) @(negedge Clk);
        checkValue("Score", Score, toBcd(12));
        endTest("score without lives");

        $display("%0d tests run, %0d failed, %0d check errors, %0d property failures",
                 testsRun, testsFailed, errorCount,
                 u_colorMapper.u_colorMapperProperties.propertyFails);
        if (errorCount == 0 && u_colorMapper.u_colorMapperProperties.propertyFails == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles before the tests finished", WatchdogCycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- tb/colorMapper_properties.sv
// checks are idle while Reset is high; Score is taken as nine BCD digits, least significant first
`timescale 1ns/10ps

module colorMapperProperties
(
    input logic               Clk,
    input logic               Reset,
    input logic               Blank,
    input gamePkg::rgb_t      Pixel,
    input gamePkg::lives_t    Lives,
    input gamePkg::scoreBcd_t Score
);

    import gamePkg::*;

    int propertyFails = 0;

    // decimal value of the score, -1 when a digit is above 9
    function automatic longint bcdValue(scoreBcd_t digits);
        longint value;
        value = 0;
        for (int i = ScoreDigits - 1; i >= 0; i--)
        begin
            if (digits[i] > 4'd9)
                return -1;
            value = value * 10 + digits[i];
        end
        return value;
    endfunction

    // ------------------------------
    // properties
    // ------------------------------
    property livesNeverRise;
        @(posedge Clk) disable iff (Reset)
        Lives <= $past(Lives);
    endproperty

    // nine nines roll over to zero
    property scoreStepsByOne;
        @(posedge Clk) disable iff (Reset)
        (Score != $past(Score)) |->
            (bcdValue($past(Score)) >= 0) &&
            (bcdValue(Score) == (bcdValue($past(Score)) + 1) % 1000000000);
    endproperty

    property blankGivesBlack;
        @(posedge Clk) disable iff (Reset)
        !Blank |=> (Pixel == BlankColor);
    endproperty

    assert property (livesNeverRise)
    else
    begin
        propertyFails++;
        $error("Lives rose to %0d without a reset", Lives);
    end

    assert property (scoreStepsByOne)
    else
    begin
        propertyFails++;
        $error("Score changed to %h, which is not one BCD step up", Score);
    end

    assert property (blankGivesBlack)
    else
    begin
        propertyFails++;
        $error("Pixel is %h one cycle after Blank was low", Pixel);
    end

endmodule

bind colorMapper colorMapperProperties u_colorMapperProperties (
    .Clk   (Clk),
    .Reset (Reset),
    .Blank (Blank),
    .Pixel (Pixel),
    .Lives (Lives),
    .Score (Score)
);

//--- verilog.f
common/gamePkg.sv
render/pixelDecode.sv
render/pixelResult.sv
gameplay/livesTracker.sv
gameplay/scoreCounter.sv
logic/colorMapper.sv
tb/clockGen.sv
tb/colorMapper_properties.sv
tb/colorMapperTb.sv
